//--- logic/omega_cfg_pkg.sv
/*
 * Omega network geometry.
 * Sizes shared by every block of the 8x8 packet switching fabric: the port
 * count, the switch point radix, the number of levels and the index widths.
 */
`default_nettype none

package omega_cfg_pkg;

  // The network connects this many input streams to as many output streams.
  localparam int unsigned NumPorts = 8;

  // Each switch point is a 2x2 crossbar.
  localparam int unsigned Radix = 2;

  // Three levels of radix 2 switch points cover eight lanes.
  localparam int unsigned NumLevels = 3;

  // Every level holds NumPorts / Radix switch points.
  localparam int unsigned NumRouters = 4;

  // Width of the destination carried by a packet, one bit per level.
  localparam int unsigned SelWidth = 3;

  // Width of the source index attached at the input side.
  localparam int unsigned IdxWidth = 3;

  // Width of the payload.
  localparam int unsigned DataWidth = 16;

  // Width of a port number inside one switch point.
  localparam int unsigned RadixIdxWidth = $clog2(Radix);

endpackage

`default_nettype wire

//--- logic/omega_pkt_pkg.sv
/*
 * Omega network packet types.
 * Requests seen at the network inputs, responses seen at the outputs, and the
 * flit that travels through the switch points in between.
 */
`default_nettype none

package omega_pkt_pkg;

  import omega_cfg_pkg::*;

  // Payload of one packet.
  typedef logic [DataWidth-1:0] data_t;

  // Number of the output a packet is routed to.
  typedef logic [SelWidth-1:0] sel_t;

  // Number of the input a packet entered through.
  typedef logic [IdxWidth-1:0] idx_t;

  // What a sender offers at each input port.
  typedef struct packed {
    sel_t  dst;
    data_t data;
  } omega_req_t;

  // What a receiver sees at each output port.
  // The source tells which input the packet came from.
  typedef struct packed {
    idx_t  src;
    data_t data;
  } omega_rsp_t;

  // The flit inside the network.
  // The destination is sliced one bit per level, and the source rides along
  // untouched until the last level.
  typedef struct packed {
    sel_t  dst;
    data_t data;
    idx_t  src;
  } omega_flit_t;

endpackage

`default_nettype wire

//--- logic/rr_arbiter.sv
/*
 * Round-robin arbiter for one switch point output.
 * The grant is combinational. An unaccepted grant is locked so the choice
 * stays put until the downstream side takes the packet, and the priority
 * pointer moves past the winner on every accepted grant.
 */
`default_nettype none

module rr_arbiter (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [omega_cfg_pkg::Radix-1:0] req_i,
  input  logic                            ready_i,
  output logic [omega_cfg_pkg::Radix-1:0] gnt_o,
  output logic                            valid_o
);
  import omega_cfg_pkg::*;

  typedef logic [RadixIdxWidth-1:0] port_idx_t;

  port_idx_t ptr_q;
  port_idx_t lock_idx_q;
  logic      lock_q;
  port_idx_t search_idx;
  logic      search_hit;
  port_idx_t win_idx;

  // Look for the first request at or after the priority pointer.
  // The search wraps around, so every requester is reached within Radix grants.
  always_comb begin : proc_search
    search_idx = ptr_q;
    search_hit = 1'b0;
    for (int unsigned off = 0; off < Radix; off++) begin
      if (!search_hit && req_i[(ptr_q + off) % Radix]) begin
        search_idx = port_idx_t'((ptr_q + off) % Radix);
        search_hit = 1'b1;
      end
    end
  end

  // A locked grant wins over a fresh search.
  // The locked request is still high, because senders keep valid up until ready.
  assign win_idx = lock_q ? lock_idx_q : search_idx;
  assign valid_o = lock_q | search_hit;

  always_comb begin : proc_gnt
    gnt_o = '0;
    if (valid_o) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // The lock lasts exactly as long as the granted packet waits for ready.
  // On acceptance the pointer steps one past the winner.
  always_ff @(posedge clk_i) begin : proc_state
    if (reset_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o & ~ready_i;
      if (valid_o && ready_i) begin
        ptr_q <= port_idx_t'((win_idx + 1) % Radix);
      end
    end
  end

  // The winner index is only looked at while lock_q is set.
  always_ff @(posedge clk_i) begin : proc_lock_idx
    if (valid_o && !ready_i) begin
      lock_idx_q <= win_idx;
    end
  end

endmodule

`default_nettype wire

//--- logic/spill_register.sv
/*
 * Spill register with two slots.
 * Data lands in the main slot and moves to the spill slot when the output
 * stalls. Ready toward the sender comes from the slot state alone, which
 * cuts the ready path and still allows one transfer per cycle.
 */
`default_nettype none

module spill_register #(
  parameter type flit_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);
  logic  a_full_q;
  logic  b_full_q;
  flit_t a_data_q;
  flit_t b_data_q;
  logic  a_fill;
  logic  a_drain;
  logic  b_fill;
  logic  b_drain;

  // The main slot fills on every input handshake.
  assign a_fill  = valid_i & ready_o;
  // It empties whenever the spill slot is free, either to the output or into the spill slot.
  assign a_drain = a_full_q & ~b_full_q;
  // A main slot entry that the output refuses is parked in the spill slot.
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin : proc_full
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_data
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // The spill slot always holds the older entry, so it goes out first.
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ~a_full_q | ~b_full_q;

endmodule

`default_nettype wire

//--- logic/stream_xbar.sv
/*
 * 2x2 switch point of the omega network.
 * Each input names one output through its select bit. A round-robin arbiter
 * per output picks among the inputs that collide, and the winner is stored
 * in that output's spill register, one pipeline stage per switch point.
 */
`default_nettype none

module stream_xbar #(
  parameter type flit_t = logic
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  flit_t [omega_cfg_pkg::Radix-1:0] data_i,
  input  logic  [omega_cfg_pkg::Radix-1:0] sel_i,
  input  logic  [omega_cfg_pkg::Radix-1:0] valid_i,
  output logic  [omega_cfg_pkg::Radix-1:0] ready_o,
  output flit_t [omega_cfg_pkg::Radix-1:0] data_o,
  output logic  [omega_cfg_pkg::Radix-1:0] valid_o,
  input  logic  [omega_cfg_pkg::Radix-1:0] ready_i
);
  import omega_cfg_pkg::*;

  // Request and grant matrices are indexed as [output][input].
  logic [Radix-1:0][Radix-1:0] out_req;
  logic [Radix-1:0][Radix-1:0] out_gnt;
  logic [Radix-1:0]            arb_valid;
  logic [Radix-1:0]            spill_ready;

  for (genvar o = 0; o < Radix; o++) begin : gen_outputs
    flit_t gnt_data;

    // An input requests this output only while it is valid and selects it.
    for (genvar i = 0; i < Radix; i++) begin : gen_req
      assign out_req[o][i] = valid_i[i] & (int'(sel_i[i]) == o);
    end

    // The arbiter sees the spill register's ready as its acceptance.
    rr_arbiter u_rr_arbiter (
      .clk_i   ( clk_i          ),
      .reset_i ( reset_i        ),
      .req_i   ( out_req[o]     ),
      .ready_i ( spill_ready[o] ),
      .gnt_o   ( out_gnt[o]     ),
      .valid_o ( arb_valid[o]   )
    );

    // Steer the granted flit toward the output stage.
    // The grant is one-hot, so at most one input matches.
    always_comb begin : proc_mux
      gnt_data = '0;
      for (int unsigned i = 0; i < Radix; i++) begin
        if (out_gnt[o][i]) begin
          gnt_data = data_i[i];
        end
      end
    end

    spill_register #(
      .flit_t ( flit_t )
    ) u_spill_register (
      .clk_i   ( clk_i          ),
      .reset_i ( reset_i        ),
      .valid_i ( arb_valid[o]   ),
      .ready_o ( spill_ready[o] ),
      .data_i  ( gnt_data       ),
      .valid_o ( valid_o[o]     ),
      .ready_i ( ready_i[o]     ),
      .data_o  ( data_o[o]      )
    );
  end

  // An input is taken when it holds the grant of an output whose spill
  // register has room. Inputs that lost arbitration or face a full output
  // keep their valid and data until a later cycle.
  // An idle input shows the room left in the output it currently selects,
  // so every input reads ready while the switch point is empty.
  always_comb begin : proc_ready
    ready_o = '0;
    for (int unsigned i = 0; i < Radix; i++) begin
      if (!valid_i[i]) begin
        ready_o[i] = spill_ready[sel_i[i]];
      end
      for (int unsigned o = 0; o < Radix; o++) begin
        if (out_gnt[o][i] && spill_ready[o]) begin
          ready_o[i] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/stream_omega_net.sv
/*
 * 8x8 omega network, the RTL top.
 * Three levels of four 2x2 switch points with a perfect shuffle between the
 * levels. Inputs enter in reverse lane order and get their source index on
 * entry. Level L routes on destination bit 2-L, and each output returns the
 * payload together with the input it came from.
 */
`default_nettype none

module stream_omega_net (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  omega_pkt_pkg::omega_req_t [omega_cfg_pkg::NumPorts-1:0] req_i,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] req_valid_i,
  output logic                      [omega_cfg_pkg::NumPorts-1:0] req_ready_o,
  output omega_pkt_pkg::omega_rsp_t [omega_cfg_pkg::NumPorts-1:0] rsp_o,
  output logic                      [omega_cfg_pkg::NumPorts-1:0] rsp_valid_o,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] rsp_ready_i
);
  import omega_cfg_pkg::*;
  import omega_pkt_pkg::*;

  // Switch point ports, indexed as [level][router][port].
  omega_flit_t [NumLevels-1:0][NumRouters-1:0][Radix-1:0] inp_data;
  logic        [NumLevels-1:0][NumRouters-1:0][Radix-1:0] inp_valid;
  logic        [NumLevels-1:0][NumRouters-1:0][Radix-1:0] inp_ready;
  omega_flit_t [NumLevels-1:0][NumRouters-1:0][Radix-1:0] out_data;
  logic        [NumLevels-1:0][NumRouters-1:0][Radix-1:0] out_valid;
  logic        [NumLevels-1:0][NumRouters-1:0][Radix-1:0] out_ready;

  // Input side.
  // Lane n of level 0 carries input port 7-n. A lane sits at router n mod 4
  // and port n div 4, the same placement the shuffle uses between levels.
  for (genvar n = 0; n < NumPorts; n++) begin : gen_inputs
    localparam int unsigned PortIdx    = NumPorts - 1 - n;
    localparam int unsigned LaneRouter = n % NumRouters;
    localparam int unsigned LaneSlot   = n / NumRouters;

    assign inp_data[0][LaneRouter][LaneSlot] = '{
      dst:  req_i[PortIdx].dst,
      data: req_i[PortIdx].data,
      src:  idx_t'(PortIdx)
    };
    assign inp_valid[0][LaneRouter][LaneSlot] = req_valid_i[PortIdx];
    assign req_ready_o[PortIdx]               = inp_ready[0][LaneRouter][LaneSlot];
  end

  // Perfect shuffle between neighbouring levels.
  // Output k of router j is lane 2j+k, which enters the next level at
  // router (2j+k) mod 4, port (2j+k) div 4. Ready runs the other way.
  for (genvar l = 0; l < NumLevels - 1; l++) begin : gen_shuffle_levels
    for (genvar j = 0; j < NumRouters; j++) begin : gen_shuffle_routers
      for (genvar k = 0; k < Radix; k++) begin : gen_shuffle_ports
        localparam int unsigned Lane       = Radix * j + k;
        localparam int unsigned LaneRouter = Lane % NumRouters;
        localparam int unsigned LaneSlot   = Lane / NumRouters;

        assign inp_data[l+1][LaneRouter][LaneSlot]  = out_data[l][j][k];
        assign inp_valid[l+1][LaneRouter][LaneSlot] = out_valid[l][j][k];
        assign out_ready[l][j][k]                   = inp_ready[l+1][LaneRouter][LaneSlot];
      end
    end
  end

  // Switch points.
  // The most significant destination bit steers level 0, the least
  // significant one the last level.
  for (genvar l = 0; l < NumLevels; l++) begin : gen_levels
    for (genvar j = 0; j < NumRouters; j++) begin : gen_routers
      logic [Radix-1:0] router_sel;

      for (genvar k = 0; k < Radix; k++) begin : gen_sel
        assign router_sel[k] = inp_data[l][j][k].dst[NumLevels-1-l];
      end

      stream_xbar #(
        .flit_t ( omega_flit_t )
      ) u_stream_xbar (
        .clk_i   ( clk_i           ),
        .reset_i ( reset_i         ),
        .data_i  ( inp_data[l][j]  ),
        .sel_i   ( router_sel      ),
        .valid_i ( inp_valid[l][j] ),
        .ready_o ( inp_ready[l][j] ),
        .data_o  ( out_data[l][j]  ),
        .valid_o ( out_valid[l][j] ),
        .ready_i ( out_ready[l][j] )
      );
    end
  end

  // Output side.
  // Lane n of the last level is output n. The destination has been used up,
  // so only the source and the payload leave the network.
  for (genvar n = 0; n < NumPorts; n++) begin : gen_outputs
    localparam int unsigned OutRouter = n / Radix;
    localparam int unsigned OutSlot   = n % Radix;

    assign rsp_o[n] = '{
      src:  out_data[NumLevels-1][OutRouter][OutSlot].src,
      data: out_data[NumLevels-1][OutRouter][OutSlot].data
    };
    assign rsp_valid_o[n]                           = out_valid[NumLevels-1][OutRouter][OutSlot];
    assign out_ready[NumLevels-1][OutRouter][OutSlot] = rsp_ready_i[n];
  end

endmodule

`default_nettype wire

//--- verif/omega_checker.sv
/*
 * Handshake checker for the omega network.
 * Bound to every instance of the network. It watches both sides of the
 * valid/ready interface and flags a sender that changes a stalled transfer.
 */
`default_nettype none

module omega_checker (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  omega_pkt_pkg::omega_req_t [omega_cfg_pkg::NumPorts-1:0] req_i,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] req_valid_i,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] req_ready_o,
  input  omega_pkt_pkg::omega_rsp_t [omega_cfg_pkg::NumPorts-1:0] rsp_o,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] rsp_valid_o,
  input  logic                      [omega_cfg_pkg::NumPorts-1:0] rsp_ready_i
);
  import omega_cfg_pkg::*;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_ports
    // A stalled request keeps its valid and its contents until it is taken.
    a_req_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      req_valid_i[p] && !req_ready_o[p] |=> req_valid_i[p] && $stable(req_i[p]))
      else $error("input %0d changed a request that was still waiting", p);

    // The network must obey the same rule toward the receivers.
    a_rsp_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_o[p] && !rsp_ready_i[p] |=> rsp_valid_o[p] && $stable(rsp_o[p]))
      else $error("output %0d changed a response that was still waiting", p);
  end

endmodule

bind stream_omega_net omega_checker u_omega_checker (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .req_i       ( req_i       ),
  .req_valid_i ( req_valid_i ),
  .req_ready_o ( req_ready_o ),
  .rsp_o       ( rsp_o       ),
  .rsp_valid_o ( rsp_valid_o ),
  .rsp_ready_i ( rsp_ready_i )
);

`default_nettype wire

//--- verif/omega_tb.sv
/*
 * Directed testbench for the 8x8 omega network.
 * Packets are queued per input and driven one time unit after the clock.
 * A negedge monitor keeps one scoreboard queue per (input, output) pair.
 */
`default_nettype none

module omega_tb;
  import omega_cfg_pkg::*;
  import omega_pkt_pkg::*;

  logic                       clk_i;
  logic                       reset_i;
  omega_req_t [NumPorts-1:0]  req;
  logic       [NumPorts-1:0]  req_valid;
  logic       [NumPorts-1:0]  req_ready;
  omega_rsp_t [NumPorts-1:0]  rsp;
  logic       [NumPorts-1:0]  rsp_valid;
  logic       [NumPorts-1:0]  rsp_ready;

  omega_req_t  send_q [NumPorts][$];
  data_t       exp_data_q [NumPorts][NumPorts][$];
  int unsigned exp_cyc_q [NumPorts][NumPorts][$];
  logic [NumPorts-1:0] in_fire = '0;
  logic [NumPorts-1:0] stalled = '0;
  omega_rsp_t  held_rsp [NumPorts];
  int unsigned stall_cnt [NumPorts];
  int unsigned cyc = 0;
  int unsigned pending = 0;
  logic [31:0] lfsr_q;
  logic        stall_en;
  logic        check_latency;
  data_t       seq_data;

  stream_omega_net u_stream_omega_net (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .req_i       ( req       ),
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .rsp_o       ( rsp       ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_ready_i ( rsp_ready )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH time %0t signal %s expected 0x%0h actual 0x%0h",
               $time, name, exp_val, act_val);
      abort_run("a checked value did not match");
    end
  endtask

  // Galois LFSR, one step per random bit.
  function automatic logic [31:0] rand_bits(input int unsigned width);
    logic [31:0] val;
    val = '0;
    for (int unsigned b = 0; b < width; b++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // The monitor runs at the negedge, where every DUT signal is settled for
  // the coming rising edge. Outputs are checked before inputs are recorded.
  always @(negedge clk_i) begin : monitor
    omega_rsp_t  got;
    data_t       exp_data;
    int unsigned exp_cyc;
    in_fire = '0;
    if (!reset_i) begin
      cyc++;
      for (int n = 0; n < NumPorts; n++) begin
        if (stalled[n]) begin
          check_value($sformatf("rsp_valid_o[%0d]", n), 1, 32'(rsp_valid[n]));
          check_value($sformatf("rsp_o[%0d]", n), 32'(held_rsp[n]), 32'(rsp[n]));
        end
        if (rsp_valid[n] && rsp_ready[n]) begin
          got = rsp[n];
          if (exp_data_q[got.src][n].size() == 0) begin
            abort_run($sformatf("output %0d delivered a packet from input %0d that was never sent",
                                n, got.src));
          end
          exp_data = exp_data_q[got.src][n].pop_front();
          exp_cyc  = exp_cyc_q[got.src][n].pop_front();
          check_value($sformatf("rsp_o[%0d].data", n), 32'(exp_data), 32'(got.data));
          // Three switch levels, each with one register stage.
          if (check_latency) begin
            check_value("latency", 3, cyc - exp_cyc);
          end
          pending--;
        end
        stalled[n]  = rsp_valid[n] & ~rsp_ready[n];
        held_rsp[n] = rsp[n];
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (req_valid[p] && req_ready[p]) begin
          in_fire[p] = 1'b1;
          exp_data_q[p][req[p].dst].push_back(req[p].data);
          exp_cyc_q[p][req[p].dst].push_back(cyc);
          pending++;
        end
      end
    end
  end

  // Accepted heads leave their queue and the next packet goes up at once.
  task automatic drive_cycle();
    for (int p = 0; p < NumPorts; p++) begin
      if (in_fire[p]) begin
        send_q[p].delete(0);
      end
      req_valid[p] = send_q[p].size() != 0;
      if (send_q[p].size() != 0) begin
        req[p] = send_q[p][0];
      end
    end
    // A stall starts with a chance of one in four and lasts up to 7 more cycles.
    for (int n = 0; n < NumPorts; n++) begin
      if (stall_cnt[n] != 0) begin
        stall_cnt[n]--;
        rsp_ready[n] = 1'b0;
      end else if (stall_en && rand_bits(2) == 0) begin
        stall_cnt[n] = rand_bits(3);
        rsp_ready[n] = 1'b0;
      end else begin
        rsp_ready[n] = 1'b1;
      end
    end
  endtask

  function automatic logic network_idle();
    for (int p = 0; p < NumPorts; p++) begin
      if (send_q[p].size() != 0) begin
        return 1'b0;
      end
    end
    return pending == 0;
  endfunction

  task automatic wait_drain(input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (!network_idle()) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
      waited++;
      if (waited > limit) begin
        abort_run($sformatf("packets still in flight after %0d cycles", limit));
      end
    end
  endtask

  task automatic send(input int p, input int d, input data_t data);
    send_q[p].push_back('{dst: sel_t'(d), data: data});
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_value("rsp_valid_o", 0, 32'(rsp_valid));
    check_value("req_ready_o", 32'((1 << NumPorts) - 1), 32'(req_ready));
  endtask

  // Every input to every output, one packet at a time.
  task automatic test_single_paths();
    check_latency = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      for (int d = 0; d < NumPorts; d++) begin
        send(p, d, seq_data);
        seq_data++;
        wait_drain(20);
      end
    end
    check_latency = 1'b0;
  endtask

  task automatic test_rotation();
    for (int b = 0; b < 4; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        send(p, (p + 3) % NumPorts, seq_data);
        seq_data++;
      end
    end
    wait_drain(200);
  endtask

  task automatic test_hotspot();
    for (int b = 0; b < 4; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        send(p, 5, seq_data);
        seq_data++;
      end
    end
    wait_drain(400);
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        send(p, (p * 3 + b) % NumPorts, seq_data);
        seq_data++;
      end
    end
    wait_drain(2000);
    stall_en = 1'b0;
  endtask

  task automatic test_random_traffic();
    int p;
    int d;
    stall_en = 1'b1;
    for (int i = 0; i < 300; i++) begin
      p = int'(rand_bits(3));
      d = int'(rand_bits(3));
      send(p, d, data_t'(rand_bits(16)));
    end
    wait_drain(20000);
    stall_en = 1'b0;
  endtask

  initial begin
    reset_i       = 1'b1;
    req           = '0;
    req_valid     = '0;
    rsp_ready     = '1;
    lfsr_q        = 32'h3e1f;
    stall_en      = 1'b0;
    check_latency = 1'b0;
    seq_data      = '0;
    for (int n = 0; n < NumPorts; n++) begin
      stall_cnt[n] = 0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset_state();
    test_single_paths();
    test_rotation();
    test_hotspot();
    test_backpressure();
    test_random_traffic();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/omega_cfg_pkg.sv
logic/omega_pkt_pkg.sv
logic/rr_arbiter.sv
logic/spill_register.sv
logic/stream_xbar.sv
logic/stream_omega_net.sv
verif/omega_checker.sv
verif/omega_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the omega network testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module omega_tb -f flist.f -o omega_sim
./obj_dir/omega_sim
